/* Makefile */
# Verilator build for the MVU lane testbench

VERILATOR ?= verilator
TOP       ?= tb_mvutop
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

SRCS := $(shell cat $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

/* compile.f */
mvu_pkg.sv
mvu_mem.sv
mvu_agu.sv
mvu_controller.sv
mvu_shiftreg.sv
mvu_vvp.sv
mvutop.sv
tb_mvutop.sv

/* mvu_agu.sv */
/*
 * MVU address generator
 * Walks a memory from a base address by a fixed stride. The address
 * is formed as base plus a running offset, so a load takes effect on
 * the same edge that captures a new base.
 */
module mvu_agu #(
    parameter int BADDR = mvu_pkg::BADDR
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             load,
    input  logic             step,
    input  logic [BADDR-1:0] base,
    input  logic [BADDR-1:0] stride,
    output logic [BADDR-1:0] addr
);

    logic [BADDR-1:0] offset_q;  // Distance walked from base

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            offset_q <= '0;
        end else if (load) begin
            offset_q <= '0;                  // Restart at base
        end else if (step) begin
            offset_q <= offset_q + stride;   // Wraps at memory depth
        end
    end

    // Sum wraps modulo 2**BADDR as well
    assign addr = base + offset_q;

endmodule

/* mvu_controller.sv */
/*
 * MVU lane controller
 * Accepts a job on the start handshake, captures its configuration
 * and counts the run cycles down from the job length. After the run
 * it waits for the result to be taken before accepting the next job.
 */
module mvu_controller (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start_valid,
    output logic             start_ready,
    input  mvu_pkg::addr_t   wbaseaddr_in,
    input  mvu_pkg::addr_t   ibaseaddr_in,
    input  mvu_pkg::addr_t   wstride_in,
    input  mvu_pkg::addr_t   istride_in,
    input  mvu_pkg::length_t length_in,
    output logic             agu_load,
    output mvu_pkg::addr_t   wbaseaddr,
    output mvu_pkg::addr_t   ibaseaddr,
    output mvu_pkg::addr_t   wstride,
    output mvu_pkg::addr_t   istride,
    output logic             run,
    output logic             run_first,
    output logic             run_last,
    input  logic             result_taken
);

    import mvu_pkg::*;

    ctrl_state_t state;
    length_t     count;    // Run cycles left after this one
    logic        first_q;  // Set for the first run cycle
    logic        accept;

    assign accept      = start_valid && start_ready;
    assign start_ready = (state == IDLE);
    assign agu_load    = accept;  // AGUs restart on the acceptance edge

    assign run       = (state == RUN);
    assign run_first = run && first_q;
    assign run_last  = run && (count == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= IDLE;
            count   <= '0;
            first_q <= 1'b0;
        end else begin
            first_q <= accept;
            case (state)
                IDLE: begin
                    if (accept) begin
                        state <= RUN;
                        count <= length_in;
                    end
                end
                RUN: begin
                    if (count == '0) begin
                        state <= WAIT_RESULT;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                WAIT_RESULT: begin
                    if (result_taken) begin
                        state <= IDLE;  // Result left the lane
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Job parameters, held for the whole job
    always_ff @(posedge clk) begin
        if (accept) begin
            wbaseaddr <= wbaseaddr_in;
            ibaseaddr <= ibaseaddr_in;
            wstride   <= wstride_in;
            istride   <= istride_in;
        end
    end

endmodule

/* mvu_mem.sv */
/*
 * MVU vector memory
 * Simple dual-port RAM with one synchronous write port and one
 * registered read port. Holds either weight or input-data words.
 */
module mvu_mem #(
    parameter int DEPTH_BITS = mvu_pkg::BADDR,
    parameter int WIDTH      = mvu_pkg::N * mvu_pkg::BELEM
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wr_en,
    input  logic [DEPTH_BITS-1:0] wr_addr,
    input  logic [WIDTH-1:0]      wr_word,
    input  logic [DEPTH_BITS-1:0] rd_addr,
    output logic [WIDTH-1:0]      rd_word
);

    logic [WIDTH-1:0] ram [2**DEPTH_BITS];  // Word array

    always_ff @(posedge clk) begin
        if (wr_en) begin
            ram[wr_addr] <= wr_word;
        end
    end

    // Read data lands one cycle after the address
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_word <= '0;
        end else begin
            rd_word <= ram[rd_addr];
        end
    end

endmodule

/* mvu_pkg.sv */
/*
 * MVU lane package
 * Widths, latencies and the vector and state types that the lane
 * modules share.
 */
package mvu_pkg;

    // Datapath geometry
    localparam int N       = 4;   // Elements per vector word
    localparam int BELEM   = 8;   // Signed element width
    localparam int BACC    = 32;  // Accumulator and result width
    localparam int BADDR   = 6;   // 64-word memories
    localparam int BLENGTH = 6;   // Job length, word count minus one

    // Pipeline latencies
    localparam int MEMRDLATENCY = 1;  // Registered memory read
    localparam int VVPSTAGES    = 1;  // Product register ahead of the accumulator

    // One memory word, N packed elements with element 0 in the low bits
    typedef logic [N*BELEM-1:0] vec_t;

    typedef logic [BADDR-1:0] addr_t;

    typedef logic [BLENGTH-1:0] length_t;

    typedef logic signed [BACC-1:0] acc_t;

    // Controller FSM
    typedef enum logic [1:0] {
        IDLE,
        RUN,
        WAIT_RESULT
    } ctrl_state_t;

endpackage

/* mvu_shiftreg.sv */
/*
 * Control delay line
 * Re-times a single control bit by DEPTH clock cycles.
 */
module mvu_shiftreg #(
    parameter int DEPTH = 1
) (
    input  logic clk,
    input  logic rst_n,
    input  logic din,
    output logic dout
);

    logic [DEPTH-1:0] chain;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            chain <= '0;
        end else begin
            chain[0] <= din;
            for (int i = 1; i < DEPTH; i++) begin
                chain[i] <= chain[i-1];
            end
        end
    end

    assign dout = chain[DEPTH-1];

endmodule

/* mvu_vvp.sv */
/*
 * MVU vector dot-product core
 * Multiplies N signed element pairs, registers their sum as the
 * product stage, then accumulates the products of one job. The final
 * sum is held in the result register until the host takes it.
 */
module mvu_vvp #(
    parameter int N = mvu_pkg::N
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [N*mvu_pkg::BELEM-1:0] wword,
    input  logic [N*mvu_pkg::BELEM-1:0] dword,
    input  logic                        acc_first,
    input  logic                        acc_last,
    output mvu_pkg::acc_t               result,
    output logic                        result_valid,
    input  logic                        result_ready,
    output logic                        result_taken
);

    import mvu_pkg::*;

    acc_t dot;       // Combinational dot product of the input words
    acc_t prod_q;    // Product stage
    acc_t acc_q;     // Running sum
    acc_t sum;
    acc_t result_q;
    logic first_q;
    logic last_q;

    always_comb begin
        logic signed [BELEM-1:0]   w_e;
        logic signed [BELEM-1:0]   d_e;
        logic signed [2*BELEM-1:0] p;
        dot = '0;
        for (int i = 0; i < N; i++) begin
            w_e = wword[i*BELEM +: BELEM];
            d_e = dword[i*BELEM +: BELEM];
            p   = w_e * d_e;
            dot = dot + p;  // Sign-extended into the accumulator width
        end
    end

    // First word of a job restarts the sum
    assign sum = first_q ? prod_q : acc_q + prod_q;

    always_ff @(posedge clk) begin
        prod_q <= dot;
        acc_q  <= sum;           // Free-running between jobs
        if (last_q) begin
            result_q <= sum;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            first_q      <= 1'b0;
            last_q       <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            first_q <= acc_first;  // Follow the product stage
            last_q  <= acc_last;
            if (last_q) begin
                result_valid <= 1'b1;
            end else if (result_taken) begin
                result_valid <= 1'b0;
            end
        end
    end

    assign result_taken = result_valid && result_ready;
    assign result       = result_q;

endmodule

/* mvutop.sv */
/*
 * MVU lane top level
 * Host-loaded weight and data memories feed a dot-product core. A job
 * walks both memories by base and stride for length+1 words and
 * returns the accumulated signed sum on a valid/ready port.
 */
module mvutop #(
    parameter int N     = mvu_pkg::N,
    parameter int BADDR = mvu_pkg::BADDR
) (
    input  logic                        clk,
    input  logic                        rst_n,
    // Weight memory write
    input  logic                        wrw_en,
    input  logic [BADDR-1:0]            wrw_addr,
    input  logic [N*mvu_pkg::BELEM-1:0] wrw_word,
    // Data memory write
    input  logic                        wrd_en,
    input  logic [BADDR-1:0]            wrd_addr,
    input  logic [N*mvu_pkg::BELEM-1:0] wrd_word,
    // Job start
    input  logic                        start_valid,
    output logic                        start_ready,
    input  logic [BADDR-1:0]            wbaseaddr,
    input  logic [BADDR-1:0]            wstride,
    input  logic [BADDR-1:0]            ibaseaddr,
    input  logic [BADDR-1:0]            istride,
    input  mvu_pkg::length_t            length,
    // Result
    output logic                        result_valid,
    input  logic                        result_ready,
    output mvu_pkg::acc_t               result
);

    import mvu_pkg::*;

    logic                 agu_load;
    logic                 run;
    logic                 run_first;
    logic                 run_last;
    logic                 acc_first;    // run_first aligned with read data
    logic                 acc_last;     // run_last aligned with read data
    logic                 result_taken;
    logic [BADDR-1:0]     wbase_q;
    logic [BADDR-1:0]     ibase_q;
    logic [BADDR-1:0]     wstride_q;
    logic [BADDR-1:0]     istride_q;
    logic [BADDR-1:0]     rdw_addr;
    logic [BADDR-1:0]     rdd_addr;
    logic [N*BELEM-1:0]   rdw_word;
    logic [N*BELEM-1:0]   rdd_word;

    mvu_controller ctrl0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_valid  (start_valid),
        .start_ready  (start_ready),
        .wbaseaddr_in (wbaseaddr),
        .ibaseaddr_in (ibaseaddr),
        .wstride_in   (wstride),
        .istride_in   (istride),
        .length_in    (length),
        .agu_load     (agu_load),
        .wbaseaddr    (wbase_q),
        .ibaseaddr    (ibase_q),
        .wstride      (wstride_q),
        .istride      (istride_q),
        .run          (run),
        .run_first    (run_first),
        .run_last     (run_last),
        .result_taken (result_taken)
    );

    mvu_agu #(.BADDR(BADDR)) wagu0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .load   (agu_load),
        .step   (run),
        .base   (wbase_q),
        .stride (wstride_q),
        .addr   (rdw_addr)
    );

    mvu_agu #(.BADDR(BADDR)) iagu0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .load   (agu_load),
        .step   (run),
        .base   (ibase_q),
        .stride (istride_q),
        .addr   (rdd_addr)
    );

    mvu_mem #(.DEPTH_BITS(BADDR), .WIDTH(N*BELEM)) wmem0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (wrw_en),
        .wr_addr (wrw_addr),
        .wr_word (wrw_word),
        .rd_addr (rdw_addr),
        .rd_word (rdw_word)
    );

    mvu_mem #(.DEPTH_BITS(BADDR), .WIDTH(N*BELEM)) dmem0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (wrd_en),
        .wr_addr (wrd_addr),
        .wr_word (wrd_word),
        .rd_addr (rdd_addr),
        .rd_word (rdd_word)
    );

    // Match the memory read latency
    mvu_shiftreg #(.DEPTH(MEMRDLATENCY)) first_dly0 (
        .clk   (clk),
        .rst_n (rst_n),
        .din   (run_first),
        .dout  (acc_first)
    );

    mvu_shiftreg #(.DEPTH(MEMRDLATENCY)) last_dly0 (
        .clk   (clk),
        .rst_n (rst_n),
        .din   (run_last),
        .dout  (acc_last)
    );

    mvu_vvp #(.N(N)) vvp0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .wword        (rdw_word),
        .dword        (rdd_word),
        .acc_first    (acc_first),
        .acc_last     (acc_last),
        .result       (result),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result_taken (result_taken)
    );

endmodule

/* tb_mvutop.sv */
/*
 * MVU lane testbench
 * Directed tests of the lane: reset state, a single-word job, a strided
 * job with negative elements, result back-pressure and a run of random
 * back-to-back jobs, all checked against a dot-product reference model.
 */
module tb_mvutop;

    import mvu_pkg::*;

    localparam int NUM_JOBS        = 23;
    localparam int WATCHDOG_CYCLES = NUM_JOBS * (64 + 10) + 200;
    localparam int WAIT_LIMIT      = 80;  // Longest job plus margin
    localparam int MEM_WORDS       = 2**BADDR;

    logic    intf;
    logic    rst_n;
    logic    wrw_en;
    addr_t   wrw_addr;
    vec_t    wrw_word;
    logic    wrd_en;
    addr_t   wrd_addr;
    vec_t    wrd_word;
    logic    start_valid;
    logic    start_ready;
    addr_t   wbaseaddr;
    addr_t   wstride;
    addr_t   ibaseaddr;
    addr_t   istride;
    length_t length;
    logic    result_valid;
    logic    result_ready;
    acc_t    result;

    vec_t wshadow [MEM_WORDS];  // Host view of the weight memory
    vec_t dshadow [MEM_WORDS];  // Host view of the data memory

    mvutop dut0 (
        .clk          (intf),
        .rst_n        (rst_n),
        .wrw_en       (wrw_en),
        .wrw_addr     (wrw_addr),
        .wrw_word     (wrw_word),
        .wrd_en       (wrd_en),
        .wrd_addr     (wrd_addr),
        .wrd_word     (wrd_word),
        .start_valid  (start_valid),
        .start_ready  (start_ready),
        .wbaseaddr    (wbaseaddr),
        .wstride      (wstride),
        .ibaseaddr    (ibaseaddr),
        .istride      (istride),
        .length       (length),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result       (result)
    );

    initial begin
        intf = 1'b0;
        forever #50 intf = ~intf;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            report_failure($sformatf("Error: %s = 0x%08h, expected 0x%08h",
                                     name, actual, expected));
        end
    endtask

    // Element 0 sits in the low byte
    function automatic vec_t pack_word(input int e0, input int e1, input int e2, input int e3);
        return {BELEM'(e3), BELEM'(e2), BELEM'(e1), BELEM'(e0)};
    endfunction

    function automatic int word_dot(input vec_t w, input vec_t d);
        int sum = 0;
        for (int i = 0; i < N; i++) begin
            sum += int'($signed(w[i*BELEM +: BELEM])) * int'($signed(d[i*BELEM +: BELEM]));
        end
        return sum;
    endfunction

    // Reference sum over length+1 words, addresses wrap at memory depth
    function automatic int expected_sum(input addr_t wb, input addr_t ws, input addr_t ib,
                                        input addr_t is, input length_t len);
        int    total = 0;
        addr_t wa;
        addr_t ia;
        for (int k = 0; k <= int'(len); k++) begin
            wa = addr_t'((int'(wb) + k * int'(ws)) % MEM_WORDS);
            ia = addr_t'((int'(ib) + k * int'(is)) % MEM_WORDS);
            total += word_dot(wshadow[wa], dshadow[ia]);
        end
        return total;
    endfunction

    task automatic write_words(input logic we, input addr_t wa, input vec_t w,
                               input logic de, input addr_t da, input vec_t d);
        @(posedge intf);
        wrw_en   <= we;
        wrw_addr <= wa;
        wrw_word <= w;
        wrd_en   <= de;
        wrd_addr <= da;
        wrd_word <= d;
        if (we) wshadow[wa] = w;
        if (de) dshadow[da] = d;
    endtask

    task automatic end_writes();
        @(posedge intf);
        wrw_en <= 1'b0;
        wrd_en <= 1'b0;
    endtask

    task automatic start_job(input addr_t wb, input addr_t ws, input addr_t ib,
                             input addr_t is, input length_t len);
        int waited = 0;
        while (start_ready !== 1'b1 && waited < WAIT_LIMIT) begin
            @(negedge intf);
            waited++;
        end
        if (start_ready !== 1'b1) report_failure("Timeout: start_ready never returned high");
        @(posedge intf);
        start_valid <= 1'b1;
        wbaseaddr   <= wb;
        wstride     <= ws;
        ibaseaddr   <= ib;
        istride     <= is;
        length      <= len;
        @(posedge intf);  // Acceptance edge
        start_valid <= 1'b0;
    endtask

    // Counts cycles from the acceptance edge until result_valid is seen
    task automatic wait_result(output int cycles);
        cycles = 0;
        while (result_valid !== 1'b1 && cycles < WAIT_LIMIT) begin
            @(negedge intf);
            cycles++;
        end
        if (result_valid !== 1'b1) report_failure("Timeout: result_valid never rose");
    endtask

    task automatic take_result();
        @(posedge intf);
        result_ready <= 1'b1;
        @(posedge intf);  // Handshake edge
        result_ready <= 1'b0;
        @(negedge intf);
        check_value("start_ready", 32'(start_ready), 32'd1);
        check_value("result_valid", 32'(result_valid), 32'd0);
    endtask

    task automatic run_job(input addr_t wb, input addr_t ws, input addr_t ib,
                           input addr_t is, input length_t len, input int expected);
        int cycles;
        start_job(wb, ws, ib, is, len);
        wait_result(cycles);
        check_value("result latency", cycles, int'(len) + MEMRDLATENCY + VVPSTAGES + 2);
        check_value("result", result, expected);
        take_result();
    endtask

    task automatic reset_state();
        check_value("start_ready", 32'(start_ready), 32'd1);
        check_value("result_valid", 32'(result_valid), 32'd0);
    endtask

    task automatic single_word_job();
        write_words(1'b1, 6'd5, pack_word(1, 2, 3, 4), 1'b1, 6'd9, pack_word(5, 6, 7, 8));
        end_writes();
        run_job(6'd5, 6'd0, 6'd9, 6'd0, 6'd0, 70);  // 5 + 12 + 21 + 32
    endtask

    task automatic strided_job();
        for (int k = 0; k < 8; k++) begin
            write_words(1'b1, addr_t'(10 + k), pack_word(-128, 127 - 9 * k, k - 4, 3 * k),
                        1'b1, addr_t'(20 + 3 * k),
                        pack_word(-128 + k, -1, 2 * k - 7, 100 - 25 * k));
        end
        end_writes();
        run_job(6'd10, 6'd1, 6'd20, 6'd3, 6'd7, expected_sum(10, 1, 20, 3, 7));
    endtask

    task automatic backpressure_job();
        int   cycles;
        int   hold;
        acc_t held;
        start_job(6'd12, 6'd1, 6'd23, 6'd3, 6'd3);  // Reuses the strided words
        wait_result(cycles);
        check_value("result latency", cycles, 3 + MEMRDLATENCY + VVPSTAGES + 2);
        check_value("result", result, expected_sum(12, 1, 23, 3, 3));
        held = result;
        hold = int'($urandom_range(20, 1));
        repeat (hold) begin
            @(negedge intf);
            check_value("result_valid", 32'(result_valid), 32'd1);
            check_value("result", result, held);
            check_value("start_ready", 32'(start_ready), 32'd0);
        end
        take_result();
    endtask

    task automatic random_jobs();
        addr_t   wb;
        addr_t   ws;
        addr_t   ib;
        addr_t   is;
        length_t len;
        for (int a = 0; a < MEM_WORDS; a++) begin
            write_words(1'b1, addr_t'(a), vec_t'($urandom), 1'b1, addr_t'(a), vec_t'($urandom));
        end
        end_writes();
        for (int j = 0; j < 20; j++) begin
            wb  = addr_t'($urandom_range(MEM_WORDS - 1, 0));
            ws  = addr_t'($urandom_range(MEM_WORDS - 1, 0));
            ib  = addr_t'($urandom_range(MEM_WORDS - 1, 0));
            is  = addr_t'($urandom_range(MEM_WORDS - 1, 0));
            len = length_t'($urandom_range(63, 0));
            run_job(wb, ws, ib, is, len, expected_sum(wb, ws, ib, is, len));
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge intf);
        report_failure($sformatf("Timeout: run did not finish within %0d cycles",
                                 WATCHDOG_CYCLES));
    end

    initial begin
        void'($urandom(43));
        rst_n        = 1'b0;
        wrw_en       = 1'b0;
        wrw_addr     = '0;
        wrw_word     = '0;
        wrd_en       = 1'b0;
        wrd_addr     = '0;
        wrd_word     = '0;
        start_valid  = 1'b0;
        wbaseaddr    = '0;
        wstride      = '0;
        ibaseaddr    = '0;
        istride      = '0;
        length       = '0;
        result_ready = 1'b0;
        repeat (16) @(posedge intf);
        rst_n <= 1'b1;
        @(negedge intf);
        reset_state();
        single_word_job();
        strided_job();
        backpressure_job();
        random_jobs();
        $display("PASS: all tests");
        $finish;
    end

endmodule
